/* logic/link_cfg_pkg.sv */
`default_nettype none

package link_cfg_pkg;

  ////////////////////////////////////////
  // Channel side
  ////////////////////////////////////////

  // User data bits per channel
  localparam int chan_width = 74;

  // Channels carried over the link
  localparam int num_chans = 4;

  // Channels left active in gen1 mode
  localparam int gen1_chans = 2;

  // Packed link word, channel 0 in the low bits
  localparam int link_width = chan_width * num_chans;

  ////////////////////////////////////////
  // PHY side
  ////////////////////////////////////////

  // One lane per channel
  localparam int lane_width = 80;
  localparam int phy_width = lane_width * num_chans;

  // Lane layout, marker right above the data
  localparam int mrk_pos = chan_width;
  localparam int stb_pos = mrk_pos + 1;

  // Whatever is left above the strobe is pad
  localparam int pad_width = lane_width - stb_pos - 1;

  // One marker user bit per lane
  localparam int mrk_width = num_chans;

  // Online sequencer counts
  localparam int delay_width = 8;

endpackage

`default_nettype wire

/* logic/link_types_pkg.sv */
`default_nettype none

package link_types_pkg;

  ////////////////////////////////////////
  // One PHY lane
  ////////////////////////////////////////

  // High to low: pad, strobe, marker, data
  // Field order must follow mrk_pos and stb_pos
  typedef struct packed {
    logic [link_cfg_pkg::pad_width-1:0]  pad;
    logic                                stb;
    logic                                mrk;
    logic [link_cfg_pkg::chan_width-1:0] data;
  } lane_t;

  ////////////////////////////////////////
  // Full PHY word
  ////////////////////////////////////////

  // Raw view faces the PHY pins
  // Lane view is what the framer builds and parses
  // Lane 0 sits in the low 80 bits
  typedef union packed {
    logic [link_cfg_pkg::phy_width-1:0] raw;
    lane_t [link_cfg_pkg::num_chans-1:0] lanes;
  } phy_word_u;

endpackage

`default_nettype wire

/* logic/link_word_if.sv */
`default_nettype none

// Link word between packer and framer
// One word per clk_wr edge, no handshake
interface link_word_if;

  // Channel k at bits k*74 and up
  logic [link_cfg_pkg::link_width-1:0] word;

  // Mode that goes with this word
  logic gen2;

  // Link state as seen right now
  logic online;

  // Word was captured while the link was up
  logic valid;

  // Producer side
  modport source (
    output word, gen2, online, valid
  );

  // Consumer side
  modport sink (
    input word, gen2, online, valid
  );

endinterface

`default_nettype wire

/* logic/online_sequencer.sv */
`default_nettype none

module online_sequencer (
  input  logic                                 clk_wr,
  input  logic                                 rst_n,

  // Raw online requests
  input  logic                                 tx_online,
  input  logic                                 rx_online,

  // Programmable delays in clk_wr cycles
  input  logic [link_cfg_pkg::delay_width-1:0] delay_x_value,
  input  logic [link_cfg_pkg::delay_width-1:0] delay_xz_value,
  input  logic [link_cfg_pkg::delay_width-1:0] delay_yz_value,

  // Configured user bits
  input  logic [link_cfg_pkg::mrk_width-1:0]   tx_mrk_userbit,
  input  logic                                 tx_stb_userbit,

  // Delayed online flags and gated user bits
  output logic                                 tx_online_delay,
  output logic                                 rx_online_delay,
  output logic [link_cfg_pkg::mrk_width-1:0]   marker_bits,
  output logic                                 strobe_bit
);

  ////////////////////////////////////////
  // Counter slots
  ////////////////////////////////////////

  // Slot 0 tx online, slot 1 rx online, slot 2 user-bit enable
  logic [2:0]                                 ctr_en;
  logic [2:0]                                 ctr_armed;
  logic [2:0]                                 ctr_done;
  logic [2:0][link_cfg_pkg::delay_width-1:0]  ctr_load;
  logic [2:0][link_cfg_pkg::delay_width-1:0]  ctr_cnt;

  // User bits wait on tx_online_delay
  // tx_online in the term so all three drop on the same edge
  assign ctr_en[0] = tx_online;
  assign ctr_en[1] = rx_online;
  assign ctr_en[2] = tx_online & ctr_done[0];

  assign ctr_load[0] = delay_xz_value;
  assign ctr_load[1] = delay_x_value;
  assign ctr_load[2] = delay_yz_value;

  ////////////////////////////////////////
  // Down-counters
  ////////////////////////////////////////

  // First edge with enable high loads the count
  // Flag rises on the edge that takes the count from 1 to 0
  // Zero delay raises the flag on the load edge itself
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ctr_armed <= '0;
      ctr_done  <= '0;
      ctr_cnt   <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (!ctr_en[i]) begin
          // Dropped enable clears the slot on the next edge
          ctr_armed[i] <= 1'b0;
          ctr_done[i]  <= 1'b0;
          ctr_cnt[i]   <= '0;
        end else if (!ctr_armed[i]) begin
          ctr_armed[i] <= 1'b1;
          ctr_cnt[i]   <= ctr_load[i];
          ctr_done[i]  <= (ctr_load[i] == '0);
        end else if (ctr_cnt[i] != '0) begin
          ctr_cnt[i] <= ctr_cnt[i] - 1'b1;
          if (ctr_cnt[i] == 1) begin
            ctr_done[i] <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign tx_online_delay = ctr_done[0];
  assign rx_online_delay = ctr_done[1];

  // Persistent marker and strobe once enabled
  assign marker_bits = ctr_done[2] ? tx_mrk_userbit : '0;
  assign strobe_bit  = ctr_done[2] & tx_stb_userbit;

endmodule

`default_nettype wire

/* logic/chan_packer.sv */
`default_nettype none

module chan_packer (
  input  logic                                clk_wr,
  input  logic                                rst_n,
  input  logic                                m_gen2_mode,

  // User words to send
  input  logic [link_cfg_pkg::chan_width-1:0] ch0_rx_data,
  input  logic [link_cfg_pkg::chan_width-1:0] ch1_rx_data,
  input  logic [link_cfg_pkg::chan_width-1:0] ch2_rx_data,
  input  logic [link_cfg_pkg::chan_width-1:0] ch3_rx_data,

  // Received user words
  output logic [link_cfg_pkg::chan_width-1:0] ch0_tx_data,
  output logic [link_cfg_pkg::chan_width-1:0] ch1_tx_data,
  output logic [link_cfg_pkg::chan_width-1:0] ch2_tx_data,
  output logic [link_cfg_pkg::chan_width-1:0] ch3_tx_data,

  input  logic                                tx_online_delay,
  input  logic                                rx_online_delay,

  link_word_if.source                         tx_link,
  link_word_if.sink                           rx_link
);

  logic [link_cfg_pkg::num_chans-1:0][link_cfg_pkg::chan_width-1:0] tx_chan;
  logic [link_cfg_pkg::num_chans-1:0][link_cfg_pkg::chan_width-1:0] rx_chan_d;
  logic [link_cfg_pkg::num_chans-1:0][link_cfg_pkg::chan_width-1:0] rx_chan_q;

  ////////////////////////////////////////
  // Transmit packing
  ////////////////////////////////////////

  // Channel 0 lands in the low bits of the link word
  always_comb begin
    tx_chan = {ch3_rx_data, ch2_rx_data, ch1_rx_data, ch0_rx_data};
    // Gen1 carries channels 0 and 1 only
    if (!m_gen2_mode) begin
      for (int k = link_cfg_pkg::gen1_chans; k < link_cfg_pkg::num_chans; k++) begin
        tx_chan[k] = '0;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    tx_link.word <= tx_chan;
  end

  // Side flags travel with the word
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_link.gen2  <= 1'b0;
      tx_link.valid <= 1'b0;
    end else begin
      tx_link.gen2  <= m_gen2_mode;
      tx_link.valid <= tx_online_delay;
    end
  end

  // Live state, lets the framer blank on the next edge
  assign tx_link.online = tx_online_delay;

  ////////////////////////////////////////
  // Receive unpacking
  ////////////////////////////////////////

  // Mode comes back with the word it was sampled with
  always_comb begin
    rx_chan_d = rx_link.word;
    if (!rx_link.gen2) begin
      for (int k = link_cfg_pkg::gen1_chans; k < link_cfg_pkg::num_chans; k++) begin
        rx_chan_d[k] = '0;
      end
    end
    // Nothing reaches the user before rx is online
    if (!rx_online_delay || !rx_link.valid) begin
      rx_chan_d = '0;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_chan_q <= '0;
    end else begin
      rx_chan_q <= rx_chan_d;
    end
  end

  assign ch0_tx_data = rx_chan_q[0];
  assign ch1_tx_data = rx_chan_q[1];
  assign ch2_tx_data = rx_chan_q[2];
  assign ch3_tx_data = rx_chan_q[3];

endmodule

`default_nettype wire

/* logic/phy_framer.sv */
`default_nettype none

module phy_framer (
  input  logic                               clk_wr,
  input  logic                               rst_n,

  link_word_if.sink                          tx_link,
  link_word_if.source                        rx_link,

  // Gated user bits from the sequencer
  input  logic [link_cfg_pkg::mrk_width-1:0] marker_bits,
  input  logic                               strobe_bit,

  // PHY pins
  output logic [link_cfg_pkg::phy_width-1:0] tx_phy0,
  input  logic [link_cfg_pkg::phy_width-1:0] rx_phy0
);

  link_types_pkg::phy_word_u             tx_frame;
  link_types_pkg::phy_word_u             rx_frame;
  logic [link_cfg_pkg::link_width-1:0]   rx_word;
  logic                                  rx_loaded;

  ////////////////////////////////////////
  // Transmit framing
  ////////////////////////////////////////

  // Lane k takes channel k plus its user bits
  always_comb begin
    tx_frame.raw = '0;
    for (int k = 0; k < link_cfg_pkg::num_chans; k++) begin
      tx_frame.lanes[k].data = tx_link.word[k*link_cfg_pkg::chan_width +: link_cfg_pkg::chan_width];
      tx_frame.lanes[k].mrk  = marker_bits[k];
      tx_frame.lanes[k].stb  = strobe_bit;
      tx_frame.lanes[k].pad  = '0;
      // Upper lanes fully quiet in gen1, user bits included
      if (!tx_link.gen2 && (k >= link_cfg_pkg::gen1_chans)) begin
        tx_frame.lanes[k] = '0;
      end
    end
  end

  // Blank while offline or while the word predates online
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
    end else if (tx_link.online && tx_link.valid) begin
      tx_phy0 <= tx_frame.raw;
    end else begin
      tx_phy0 <= '0;
    end
  end

  ////////////////////////////////////////
  // Receive parsing
  ////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    rx_frame.raw <= rx_phy0;
  end

  // High from the first capture after reset
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_loaded <= 1'b0;
    end else begin
      rx_loaded <= 1'b1;
    end
  end

  // Keep data bits only
  always_comb begin
    rx_word = '0;
    for (int k = 0; k < link_cfg_pkg::num_chans; k++) begin
      rx_word[k*link_cfg_pkg::chan_width +: link_cfg_pkg::chan_width] = rx_frame.lanes[k].data;
    end
  end

  assign rx_link.word  = rx_word;
  assign rx_link.valid = rx_loaded;

  // Mode register lines up with the rx capture edge
  assign rx_link.gen2   = tx_link.gen2;
  assign rx_link.online = tx_link.online;

endmodule

`default_nettype wire

/* logic/link_slave_top.sv */
`default_nettype none

module link_slave_top (
  input  logic                                 clk_wr,
  input  logic                                 rst_n,

  // Online control
  input  logic                                 tx_online,
  input  logic                                 rx_online,

  // PHY word
  output logic [link_cfg_pkg::phy_width-1:0]   tx_phy0,
  input  logic [link_cfg_pkg::phy_width-1:0]   rx_phy0,

  // Received channels
  output logic [link_cfg_pkg::chan_width-1:0]  ch0_tx_data,
  output logic [link_cfg_pkg::chan_width-1:0]  ch1_tx_data,
  output logic [link_cfg_pkg::chan_width-1:0]  ch2_tx_data,
  output logic [link_cfg_pkg::chan_width-1:0]  ch3_tx_data,

  // Channels to send
  input  logic [link_cfg_pkg::chan_width-1:0]  ch0_rx_data,
  input  logic [link_cfg_pkg::chan_width-1:0]  ch1_rx_data,
  input  logic [link_cfg_pkg::chan_width-1:0]  ch2_rx_data,
  input  logic [link_cfg_pkg::chan_width-1:0]  ch3_rx_data,

  // Configuration
  input  logic                                 m_gen2_mode,
  input  logic [link_cfg_pkg::mrk_width-1:0]   tx_mrk_userbit,
  input  logic                                 tx_stb_userbit,
  input  logic [link_cfg_pkg::delay_width-1:0] delay_x_value,
  input  logic [link_cfg_pkg::delay_width-1:0] delay_xz_value,
  input  logic [link_cfg_pkg::delay_width-1:0] delay_yz_value
);

  logic                               tx_online_delay;
  logic                               rx_online_delay;
  logic [link_cfg_pkg::mrk_width-1:0] marker_bits;
  logic                               strobe_bit;

  // Packer to framer and back
  link_word_if tx_link ();
  link_word_if rx_link ();

  ////////////////////////////////////////
  // Online sequencing
  ////////////////////////////////////////

  online_sequencer sequencer_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_xz_value  (delay_xz_value),
    .delay_yz_value  (delay_yz_value),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .marker_bits     (marker_bits),
    .strobe_bit      (strobe_bit)
  );

  ////////////////////////////////////////
  // Channel stage
  ////////////////////////////////////////

  chan_packer packer_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .m_gen2_mode     (m_gen2_mode),
    .ch0_rx_data     (ch0_rx_data),
    .ch1_rx_data     (ch1_rx_data),
    .ch2_rx_data     (ch2_rx_data),
    .ch3_rx_data     (ch3_rx_data),
    .ch0_tx_data     (ch0_tx_data),
    .ch1_tx_data     (ch1_tx_data),
    .ch2_tx_data     (ch2_tx_data),
    .ch3_tx_data     (ch3_tx_data),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_link         (tx_link.source),
    .rx_link         (rx_link.sink)
  );

  ////////////////////////////////////////
  // Lane stage
  ////////////////////////////////////////

  phy_framer framer_i (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_link     (tx_link.sink),
    .rx_link     (rx_link.source),
    .marker_bits (marker_bits),
    .strobe_bit  (strobe_bit),
    .tx_phy0     (tx_phy0),
    .rx_phy0     (rx_phy0)
  );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`default_nettype none

module clk_gen (
  output logic clk_wr,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period
  initial begin
    clk_wr = 1'b0;
    forever #50 clk_wr = ~clk_wr;
  end

  // Reset held for 10 cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk_wr);
    @(negedge clk_wr);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/link_checker.sv */
`default_nettype none

module link_checker (
  input logic                               clk_wr,
  input logic                               rst_n,
  input logic [link_cfg_pkg::phy_width-1:0] tx_phy0,
  input logic                               online,
  input logic                               gen2
);

  timeunit 1ns;
  timeprecision 1ps;

  link_types_pkg::phy_word_u          view;
  logic [link_cfg_pkg::num_chans-1:0] pad_set;

  // Failed assertions so far
  int error_count = 0;

  assign view.raw = tx_phy0;

  // One flag per lane, set when any pad bit is high
  always_comb begin
    for (int k = 0; k < link_cfg_pkg::num_chans; k++) begin
      pad_set[k] = |view.lanes[k].pad;
    end
  end

  ////////////////////////////////////////
  // Framing rules
  ////////////////////////////////////////

  pad_zero_a: assert property (@(posedge clk_wr) disable iff (!rst_n) pad_set == '0)
    else begin
      $error("pad bits set on tx_phy0");
      error_count++;
    end

  // Offline word leaves a blank PHY word behind it
  offline_zero_a: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !online |=> tx_phy0 == '0)
    else begin
      $error("tx_phy0 not blank after offline edge");
      error_count++;
    end

  // Gen1 keeps lanes 2 and 3 quiet
  gen1_quiet_a: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !gen2 |=> (view.lanes[2] == '0 && view.lanes[3] == '0))
    else begin
      $error("upper lanes active in gen1 mode");
      error_count++;
    end

endmodule

bind phy_framer link_checker checker_i (
  .clk_wr  (clk_wr),
  .rst_n   (rst_n),
  .tx_phy0 (tx_phy0),
  .online  (tx_link.online),
  .gen2    (tx_link.gen2)
);

`default_nettype wire

/* verif/link_tb.sv */
`default_nettype none

module link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                                 clk_wr;
  logic                                 rst_n;
  logic                                 tx_online;
  logic                                 rx_online;
  logic                                 m_gen2_mode;
  logic [link_cfg_pkg::mrk_width-1:0]   tx_mrk_userbit;
  logic                                 tx_stb_userbit;
  logic [link_cfg_pkg::delay_width-1:0] delay_x_value;
  logic [link_cfg_pkg::delay_width-1:0] delay_xz_value;
  logic [link_cfg_pkg::delay_width-1:0] delay_yz_value;
  logic [link_cfg_pkg::phy_width-1:0]   tx_phy0;
  logic [link_cfg_pkg::phy_width-1:0]   rx_phy0;
  logic [link_cfg_pkg::chan_width-1:0]  ch_in [link_cfg_pkg::num_chans];
  logic [link_cfg_pkg::chan_width-1:0]  ch_out [link_cfg_pkg::num_chans];
  logic [link_cfg_pkg::chan_width-1:0]  ch0_tx_data;
  logic [link_cfg_pkg::chan_width-1:0]  ch1_tx_data;
  logic [link_cfg_pkg::chan_width-1:0]  ch2_tx_data;
  logic [link_cfg_pkg::chan_width-1:0]  ch3_tx_data;

  // Test segments from the data file
  int q_cyc[$];
  int q_mode[$];
  int q_dx[$];
  int q_dxz[$];
  int q_dyz[$];
  int q_mrk[$];
  int q_stb[$];
  int q_txon[$];
  int q_rxon[$];
  int q_etx[$];
  int q_erx[$];
  int q_eusr[$];

  // Counter model, state after the last edge
  logic                                 arm0;
  logic                                 arm1;
  logic                                 arm2;
  logic                                 d0;
  logic                                 d1;
  logic                                 d2;
  logic                                 prev_d0;
  logic [link_cfg_pkg::delay_width-1:0] cnt0;
  logic [link_cfg_pkg::delay_width-1:0] cnt1;
  logic [link_cfg_pkg::delay_width-1:0] cnt2;
  logic [link_cfg_pkg::chan_width-1:0]  p_data [link_cfg_pkg::num_chans];
  logic                                 p_mode;
  logic [link_cfg_pkg::phy_width-1:0]   p_rx;

  int seed = 32'hd1a3_bc2c;
  int cycle_count = 0;
  int cycle_limit = 0;

  assign ch_out[0] = ch0_tx_data;
  assign ch_out[1] = ch1_tx_data;
  assign ch_out[2] = ch2_tx_data;
  assign ch_out[3] = ch3_tx_data;

  clk_gen clk_gen_i (.clk_wr(clk_wr), .rst_n(rst_n));

  link_slave_top dut_i (
    .clk_wr (clk_wr), .rst_n (rst_n),
    .tx_online (tx_online), .rx_online (rx_online),
    .tx_phy0 (tx_phy0), .rx_phy0 (rx_phy0),
    .ch0_tx_data (ch0_tx_data), .ch1_tx_data (ch1_tx_data),
    .ch2_tx_data (ch2_tx_data), .ch3_tx_data (ch3_tx_data),
    .ch0_rx_data (ch_in[0]), .ch1_rx_data (ch_in[1]),
    .ch2_rx_data (ch_in[2]), .ch3_rx_data (ch_in[3]),
    .m_gen2_mode (m_gen2_mode), .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit), .delay_x_value (delay_x_value),
    .delay_xz_value (delay_xz_value), .delay_yz_value (delay_yz_value)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic fail_now(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    int    c, mo, dx, dxz, dyz, mk, sb, tn, rn, et, er, eu;
    fd = $fopen("verif/link_tests.txt", "r");
    if (fd == 0) begin
      fail_now("cannot open verif/link_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Blank lines and comment lines carry nothing
        if (line.len() > 1 && line.substr(0, 1) != "//") begin
          n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h",
                      c, mo, dx, dxz, dyz, mk, sb, tn, rn, et, er, eu);
          if (n != 12) begin
            fail_now($sformatf("malformed line in test file: %s", line));
          end else begin
            q_cyc.push_back(c);
            q_mode.push_back(mo);
            q_dx.push_back(dx);
            q_dxz.push_back(dxz);
            q_dyz.push_back(dyz);
            q_mrk.push_back(mk);
            q_stb.push_back(sb);
            q_txon.push_back(tn);
            q_rxon.push_back(rn);
            q_etx.push_back(et);
            q_erx.push_back(er);
            q_eusr.push_back(eu);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Load on first enabled edge, flag once the count reaches zero
  task automatic count_step(input logic en, input logic [7:0] load,
                            inout logic armed, inout logic [7:0] cnt, inout logic done);
    if (!en) begin
      armed = 1'b0;
      done  = 1'b0;
      cnt   = '0;
    end else if (!armed) begin
      armed = 1'b1;
      cnt   = load;
      done  = (load == 8'd0);
    end else if (cnt != 8'd0) begin
      cnt = cnt - 8'd1;
      if (cnt == 8'd0) begin
        done = 1'b1;
      end
    end
  endtask

  task automatic random_data();
    logic [95:0] wide;
    for (int k = 0; k < link_cfg_pkg::num_chans; k++) begin
      wide     = {$random(seed), $random(seed), $random(seed)};
      ch_in[k] = wide[link_cfg_pkg::chan_width-1:0];
    end
    for (int w = 0; w < 10; w++) begin
      rx_phy0[w*32 +: 32] = $random(seed);
    end
  endtask

  ////////////////////////////////////////
  // One clock: check, then advance the model
  ////////////////////////////////////////

  task automatic step_cycle();
    link_types_pkg::lane_t [link_cfg_pkg::num_chans-1:0] lanes;
    logic [link_cfg_pkg::phy_width-1:0]  exp_tx;
    logic [link_cfg_pkg::chan_width-1:0] exp_ch;
    logic                                en2;
    @(negedge clk_wr);
    // Word from the edge before, user bits as configured now
    for (int k = 0; k < link_cfg_pkg::num_chans; k++) begin
      lanes[k].pad  = '0;
      lanes[k].stb  = d2 & tx_stb_userbit;
      lanes[k].mrk  = d2 & tx_mrk_userbit[k];
      lanes[k].data = p_data[k];
      if (!p_mode && k >= link_cfg_pkg::gen1_chans) begin
        lanes[k] = '0;
      end
    end
    exp_tx = (d0 && prev_d0) ? lanes : '0;
    assert (tx_phy0 == exp_tx) else
      fail_now($sformatf("mismatch at %0t ns: tx_phy0 %h expected %h", $time, tx_phy0, exp_tx));
    for (int k = 0; k < link_cfg_pkg::num_chans; k++) begin
      exp_ch = d1 ? p_rx[k*link_cfg_pkg::lane_width +: link_cfg_pkg::chan_width] : '0;
      if (!p_mode && k >= link_cfg_pkg::gen1_chans) begin
        exp_ch = '0;
      end
      assert (ch_out[k] == exp_ch) else
        fail_now($sformatf("mismatch at %0t ns: ch%0d_tx_data %h expected %h",
                           $time, k, ch_out[k], exp_ch));
    end
    en2     = tx_online & d0;
    prev_d0 = d0;
    count_step(tx_online, delay_xz_value, arm0, cnt0, d0);
    count_step(rx_online, delay_x_value, arm1, cnt1, d1);
    count_step(en2, delay_yz_value, arm2, cnt2, d2);
    p_data = ch_in;
    p_mode = m_gen2_mode;
    p_rx   = rx_phy0;
  endtask

  // Cycle limit from the test length
  always @(posedge clk_wr) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      fail_now("timeout: cycle limit reached before the tests ended");
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int total;
    int mx;
    int mxz;
    int myz;
    tx_online = 1'b0;
    rx_online = 1'b0;
    m_gen2_mode = 1'b0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value = '0;
    delay_xz_value = '0;
    delay_yz_value = '0;
    rx_phy0 = '0;
    for (int k = 0; k < link_cfg_pkg::num_chans; k++) begin
      ch_in[k]  = '0;
      p_data[k] = '0;
    end
    {arm0, arm1, arm2, d0, d1, d2, prev_d0, p_mode} = '0;
    {cnt0, cnt1, cnt2} = '0;
    p_rx = '0;
    load_tests();
    total = 0;
    mx = 0;
    mxz = 0;
    myz = 0;
    foreach (q_cyc[i]) begin
      total += q_cyc[i];
      if (q_dx[i] > mx) mx = q_dx[i];
      if (q_dxz[i] > mxz) mxz = q_dxz[i];
      if (q_dyz[i] > myz) myz = q_dyz[i];
    end
    cycle_limit = total + mx + mxz + myz + 50;
    wait (rst_n === 1'b1);
    // Idle edge right after reset, all outputs zero
    step_cycle();
    foreach (q_cyc[i]) begin
      for (int c = 0; c < q_cyc[i]; c++) begin
        m_gen2_mode    = q_mode[i][0];
        delay_x_value  = q_dx[i][7:0];
        delay_xz_value = q_dxz[i][7:0];
        delay_yz_value = q_dyz[i][7:0];
        tx_mrk_userbit = q_mrk[i][3:0];
        tx_stb_userbit = q_stb[i][0];
        tx_online      = q_txon[i][0];
        rx_online      = q_rxon[i][0];
        random_data();
        step_cycle();
      end
      assert (d0 == q_etx[i][0] && d1 == q_erx[i][0] && d2 == q_eusr[i][0]) else
        fail_now($sformatf("counter model disagrees with test file at segment %0d", i));
      assert (dut_i.tx_online_delay == q_etx[i][0]) else
        fail_now($sformatf("mismatch at %0t ns: tx_online_delay wrong after segment %0d",
                           $time, i));
      assert (dut_i.rx_online_delay == q_erx[i][0]) else
        fail_now($sformatf("mismatch at %0t ns: rx_online_delay wrong after segment %0d",
                           $time, i));
    end
    // Drain the two-stage pipeline
    tx_online = 1'b0;
    rx_online = 1'b0;
    repeat (2) step_cycle();
    // Framing assertions in the bound checker count their own failures
    if (dut_i.framer_i.checker_i.error_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_now("framing assertions failed during the run");
    end
  end

endmodule

`default_nettype wire

/* verif/link_tests.txt */
// cycles(dec) mode dx dxz dyz mrk stb txon rxon | expected after segment: tx_dly rx_dly usr_en
// Hex fields after cycles; channel and rx PHY data are random per cycle
5 1 03 04 02 a 1 0 0 0 0 0
3 1 03 04 02 a 1 1 1 0 0 0
2 1 03 04 02 a 1 1 1 1 1 0
4 1 03 04 02 a 1 1 1 1 1 1
6 1 03 04 02 a 1 1 1 1 1 1
1 1 03 04 02 a 1 0 1 0 1 0
3 1 03 04 02 a 1 0 0 0 0 0
// Gen1 with zero delays
2 0 00 00 00 5 0 1 1 1 1 1
8 0 00 00 00 5 0 1 1 1 1 1
8 1 00 00 00 3 1 1 1 1 1 1
1 1 00 00 00 3 1 1 0 1 0 1
4 1 02 00 00 3 1 1 1 1 1 1
// tx drop and re-arm with short delays
2 1 02 01 01 c 1 0 1 0 1 0
2 1 02 01 01 c 1 1 1 1 1 0
2 1 02 01 01 c 1 1 1 1 1 1
10 1 02 01 01 f 1 1 1 1 1 1
4 0 02 01 01 f 1 1 1 1 1 1
4 1 02 01 01 0 0 0 0 0 0 0

/* project.f */
logic/link_cfg_pkg.sv
logic/link_types_pkg.sv
logic/link_word_if.sv
logic/online_sequencer.sv
logic/chan_packer.sv
logic/phy_framer.sv
logic/link_slave_top.sv
verif/clk_gen.sv
verif/link_checker.sv
verif/link_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module link_tb -f project.f -o link_sim

status=0
./obj_dir/link_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Something failed" sim.log || [ "$status" -ne 0 ]; then
  exit 1
fi
exit 0
